// File: hw/segdisp_pkg.sv
package segdisp_pkg;

    // Chunk geometry
    localparam int CHUNK_LEN   = 5;
    localparam int LOC_W       = 3;
    localparam int CHUNK_IDX_W = 8;

    // FIFO bank, one FIFO per decoder
    localparam int NUM_FIFOS   = 4;
    localparam int FIFO_SEL_W  = 2;
    localparam int FIFO_DEPTH  = 4;
    localparam int FIFO_ADDR_W = $clog2(FIFO_DEPTH);

    typedef logic [CHUNK_LEN-1:0]   marker_t;     // One bit per symbol position
    typedef logic [LOC_W-1:0]       loc_t;        // Start position inside a chunk
    typedef logic [CHUNK_IDX_W-1:0] chunk_idx_t;  // Wraps
    typedef logic [FIFO_SEL_W-1:0]  fifo_sel_t;
    typedef logic [NUM_FIFOS-1:0]   fifo_mask_t;
    typedef logic [1:0]             write_cnt_t;  // 0 to 2 starts

    // Internal FIFO bookkeeping
    typedef logic [FIFO_ADDR_W-1:0] fifo_addr_t;
    typedef logic [FIFO_ADDR_W:0]   fifo_cnt_t;   // 0 to FIFO_DEPTH

endpackage

// File: hw/boundary_detector.sv
module boundary_detector import segdisp_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       en,
    input  logic       flush,

    input  logic       chunk_valid,
    output logic       chunk_ready,
    input  marker_t    chunk_markers,

    input  fifo_mask_t afull,
    input  fifo_mask_t init_n,

    output logic       stage_valid,
    output logic       is_there_edge,
    output loc_t       loc_1,
    output loc_t       loc_2,
    output write_cnt_t num_of_writes,
    output chunk_idx_t chunk_idx
);

    logic       accept;
    write_cnt_t cnt_now;
    loc_t       first_loc;
    loc_t       second_loc;
    chunk_idx_t chunk_cnt;

    // Hold off while disabled, while the FIFOs come out of init, or near full
    assign chunk_ready = en && (&init_n) && !(|afull) && !flush;
    assign accept      = chunk_valid && chunk_ready;

    // First two starts among positions 0 to CHUNK_LEN-2
    always_comb begin
        cnt_now    = '0;
        first_loc  = '0;
        second_loc = '0;
        for (int i = 0; i < CHUNK_LEN - 1; i++) begin
            if (chunk_markers[i]) begin
                if (cnt_now == 2'd0) begin
                    first_loc = loc_t'(i);
                end else if (cnt_now == 2'd1) begin
                    second_loc = loc_t'(i);
                end
                if (cnt_now != 2'd2) begin
                    cnt_now = cnt_now + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage_valid   <= 1'b0;
            is_there_edge <= 1'b0;
            chunk_cnt     <= '0;
        end else begin
            stage_valid <= accept;
            if (flush) begin
                is_there_edge <= 1'b0;
                chunk_cnt     <= '0;
            end else if (accept) begin
                is_there_edge <= chunk_markers[CHUNK_LEN-1];  // Deferred to next chunk
                chunk_cnt     <= chunk_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            loc_1         <= first_loc;
            loc_2         <= second_loc;
            num_of_writes <= cnt_now;
            chunk_idx     <= chunk_cnt;
        end
    end

    // A carried edge takes one of the two push slots of this chunk
    a_max_two_starts: assert property (
        @(posedge clk) disable iff (!rst_n)
        accept |-> ($countones(chunk_markers[CHUNK_LEN-2:0]) + is_there_edge) <= 2
    );

endmodule

// File: hw/fifo_controller.sv
module fifo_controller import segdisp_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       en_fifo,
    input  logic       flush,

    input  logic       stage_valid,
    input  logic       is_there_edge,
    input  loc_t       loc_1,
    input  loc_t       loc_2,
    input  write_cnt_t num_of_writes,

    output fifo_mask_t push_n,
    output fifo_mask_t clr,
    output fifo_mask_t init_n,
    output loc_t       start_loc [NUM_FIFOS]
);

    logic       enabled;
    logic       prev_edge;
    fifo_sel_t  w_ptr_0;
    fifo_sel_t  w_ptr_1;
    fifo_mask_t push;
    write_cnt_t n_push;
    write_cnt_t adv;
    loc_t       first_loc;
    loc_t       second_loc;

    function automatic fifo_sel_t wrap_add(fifo_sel_t ptr, write_cnt_t step);
        logic [FIFO_SEL_W:0] sum;
        sum = ptr + step;
        if (sum >= NUM_FIFOS) begin
            sum = sum - (FIFO_SEL_W + 1)'(NUM_FIFOS);
        end
        return fifo_sel_t'(sum);
    endfunction

    assign init_n = {NUM_FIFOS{enabled && en_fifo}};
    assign clr    = {NUM_FIFOS{flush}};
    assign push_n = ~push;

    assign n_push     = num_of_writes + write_cnt_t'(prev_edge);
    assign first_loc  = prev_edge ? loc_t'(0) : loc_1;  // Carried start opens the chunk
    assign second_loc = prev_edge ? loc_1 : loc_2;

    always_comb begin
        push = '0;
        adv  = '0;
        for (int i = 0; i < NUM_FIFOS; i++) begin
            start_loc[i] = '0;
        end
        if (stage_valid) begin
            case (n_push)
                2'd1: begin
                    push[w_ptr_0]      = 1'b1;
                    start_loc[w_ptr_0] = first_loc;
                    adv                = 2'd1;
                end
                2'd2: begin
                    push[w_ptr_0]      = 1'b1;
                    push[w_ptr_1]      = 1'b1;
                    start_loc[w_ptr_0] = first_loc;
                    start_loc[w_ptr_1] = second_loc;
                    adv                = 2'd2;
                end
                default: ;  // Nothing to push, or an illegal chunk
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            enabled   <= 1'b0;
            prev_edge <= 1'b0;
            w_ptr_0   <= fifo_sel_t'(0);
            w_ptr_1   <= fifo_sel_t'(1);
        end else begin
            enabled <= en_fifo;  // One cycle behind en_fifo
            if (flush) begin
                prev_edge <= 1'b0;
                w_ptr_0   <= fifo_sel_t'(0);
                w_ptr_1   <= fifo_sel_t'(1);
            end else if (stage_valid) begin
                prev_edge <= is_there_edge;
                w_ptr_0   <= wrap_add(w_ptr_0, adv);
                w_ptr_1   <= wrap_add(w_ptr_1, adv);
            end
        end
    end

    // Every owed start lands in its own FIFO, never more than two per chunk
    a_two_pushes_max: assert property (
        @(posedge clk) disable iff (!rst_n)
        $countones(~push_n) == (stage_valid ? int'(n_push) : 0)
    );

endmodule

// File: hw/start_fifo.sv
module start_fifo import segdisp_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       push_n,
    input  logic       init_n,
    input  logic       clr,
    input  chunk_idx_t wr_chunk,
    input  loc_t       wr_loc,
    input  logic       pop,
    output chunk_idx_t rd_chunk,
    output loc_t       rd_loc,
    output logic       empty,
    output logic       afull
);

    chunk_idx_t mem_chunk [FIFO_DEPTH];
    loc_t       mem_loc   [FIFO_DEPTH];
    fifo_addr_t wr_ptr;
    fifo_addr_t rd_ptr;
    fifo_cnt_t  count;
    logic       full;
    logic       wipe;
    logic       do_push;
    logic       do_pop;

    assign wipe    = !init_n || clr;
    assign do_push = !push_n;
    assign do_pop  = pop;

    assign empty = (count == '0);
    assign full  = (count == fifo_cnt_t'(FIFO_DEPTH));
    assign afull = (fifo_cnt_t'(FIFO_DEPTH) - count) < 2;  // Room for less than one chunk

    assign rd_chunk = mem_chunk[rd_ptr];
    assign rd_loc   = mem_loc[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (wipe) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == fifo_addr_t'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == fifo_addr_t'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push && !wipe) begin
            mem_chunk[wr_ptr] <= wr_chunk;
            mem_loc[wr_ptr]   <= wr_loc;
        end
    end

    // The detector's afull gating must keep pushes away from a full FIFO
    a_no_overflow: assert property (
        @(posedge clk) disable iff (!rst_n || wipe) do_push |-> !full
    );

    a_no_underflow: assert property (
        @(posedge clk) disable iff (!rst_n || wipe) do_pop |-> !empty
    );

endmodule

// File: hw/start_drain.sv
module start_drain import segdisp_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       flush,

    input  fifo_mask_t empty,
    input  chunk_idx_t rd_chunk [NUM_FIFOS],
    input  loc_t       rd_loc   [NUM_FIFOS],
    output fifo_mask_t pop,

    output logic       seg_valid,
    input  logic       seg_ready,
    output chunk_idx_t seg_chunk,
    output loc_t       seg_loc
);

    fifo_sel_t rd_sel;
    logic      seg_fire;

    // Stay on the current FIFO until it delivers, which keeps global order
    assign seg_valid = !empty[rd_sel];
    assign seg_chunk = rd_chunk[rd_sel];
    assign seg_loc   = rd_loc[rd_sel];
    assign seg_fire  = seg_valid && seg_ready;

    always_comb begin
        pop = '0;
        if (seg_fire) begin
            pop[rd_sel] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_sel <= '0;
        end else if (flush) begin
            rd_sel <= '0;  // Matches write pointer restart
        end else if (seg_fire) begin
            if (rd_sel == fifo_sel_t'(NUM_FIFOS - 1)) begin
                rd_sel <= '0;
            end else begin
                rd_sel <= rd_sel + 1'b1;
            end
        end
    end

endmodule

// File: hw/segment_dispatch_top.sv
module segment_dispatch_top import segdisp_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       en,
    input  logic       flush,

    input  logic       chunk_valid,
    output logic       chunk_ready,
    input  marker_t    chunk_markers,

    output logic       seg_valid,
    input  logic       seg_ready,
    output chunk_idx_t seg_chunk,
    output loc_t       seg_loc
);

    logic       stage_valid;
    logic       is_there_edge;
    loc_t       loc_1;
    loc_t       loc_2;
    write_cnt_t num_of_writes;
    chunk_idx_t chunk_idx;

    fifo_mask_t push_n;
    fifo_mask_t clr;
    fifo_mask_t init_n;
    fifo_mask_t pop;
    fifo_mask_t empty;
    fifo_mask_t afull;
    loc_t       start_loc [NUM_FIFOS];
    chunk_idx_t rd_chunk  [NUM_FIFOS];
    loc_t       rd_loc    [NUM_FIFOS];

    boundary_detector u_detector (
        .clk           (clk),
        .rst_n         (rst_n),
        .en            (en),
        .flush         (flush),
        .chunk_valid   (chunk_valid),
        .chunk_ready   (chunk_ready),
        .chunk_markers (chunk_markers),
        .afull         (afull),
        .init_n        (init_n),
        .stage_valid   (stage_valid),
        .is_there_edge (is_there_edge),
        .loc_1         (loc_1),
        .loc_2         (loc_2),
        .num_of_writes (num_of_writes),
        .chunk_idx     (chunk_idx)
    );

    fifo_controller u_controller (
        .clk           (clk),
        .rst_n         (rst_n),
        .en_fifo       (en),
        .flush         (flush),
        .stage_valid   (stage_valid),
        .is_there_edge (is_there_edge),
        .loc_1         (loc_1),
        .loc_2         (loc_2),
        .num_of_writes (num_of_writes),
        .push_n        (push_n),
        .clr           (clr),
        .init_n        (init_n),
        .start_loc     (start_loc)
    );

    for (genvar gi = 0; gi < NUM_FIFOS; gi++) begin : g_fifo
        start_fifo u_fifo (
            .clk      (clk),
            .rst_n    (rst_n),
            .push_n   (push_n[gi]),
            .init_n   (init_n[gi]),
            .clr      (clr[gi]),
            .wr_chunk (chunk_idx),
            .wr_loc   (start_loc[gi]),
            .pop      (pop[gi]),
            .rd_chunk (rd_chunk[gi]),
            .rd_loc   (rd_loc[gi]),
            .empty    (empty[gi]),
            .afull    (afull[gi])
        );
    end

    start_drain u_drain (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .empty     (empty),
        .rd_chunk  (rd_chunk),
        .rd_loc    (rd_loc),
        .pop       (pop),
        .seg_valid (seg_valid),
        .seg_ready (seg_ready),
        .seg_chunk (seg_chunk),
        .seg_loc   (seg_loc)
    );

endmodule

// File: test/tb_segment_dispatch.sv
module tb_segment_dispatch import segdisp_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    logic       clk;
    logic       rst_n;
    logic       en;
    logic       flush;
    logic       chunk_valid;
    logic       chunk_ready;
    marker_t    chunk_markers;
    logic       seg_valid;
    logic       seg_ready;
    chunk_idx_t seg_chunk;
    loc_t       seg_loc;

    byte        cmd_kind  [$];
    int         cmd_arg   [$];
    int         cmd_mark  [$];  // Records that must be out before a D or F step
    chunk_idx_t exp_chunk [$];
    loc_t       exp_loc   [$];
    int         matched = 0;
    int         cycles = 0;
    int         timeout_cycles = 0;
    integer     seed = 32'h267df498;

    segment_dispatch_top DUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .en            (en),
        .flush         (flush),
        .chunk_valid   (chunk_valid),
        .chunk_ready   (chunk_ready),
        .chunk_markers (chunk_markers),
        .seg_valid     (seg_valid),
        .seg_ready     (seg_ready),
        .seg_chunk     (seg_chunk),
        .seg_loc       (seg_loc)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run();
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic check_chunk(input chunk_idx_t got, input chunk_idx_t exp);
        if (got !== exp) begin
            $display("MISMATCH %0d ns: seg_chunk is %0d, expected %0d in record %0d",
                     $time, got, exp, matched);
            abort_run();
        end
    endtask

    task automatic check_loc(input loc_t got, input loc_t exp);
        if (got !== exp) begin
            $display("MISMATCH %0d ns: seg_loc is %0d, expected %0d in record %0d",
                     $time, got, exp, matched);
            abort_run();
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH %0d ns: %s is %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic load_testdata();
        int    fd;
        int    a;
        int    b;
        byte   kind;
        string line;
        fd = $fopen("test/segment_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open test/segment_testdata.txt for reading");
            abort_run();
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                kind = line.getc(0);
                a = 0;
                b = 0;
                if (kind == "E") begin
                    void'($sscanf(line, "E %d %d", a, b));
                    exp_chunk.push_back(chunk_idx_t'(a));
                    exp_loc.push_back(loc_t'(b));
                end else if (kind == "C" || kind == "D" || kind == "F") begin
                    if (kind == "C") begin
                        void'($sscanf(line, "C %b", a));
                    end else if (kind == "D") begin
                        void'($sscanf(line, "D %d", a));
                    end
                    cmd_kind.push_back(kind);
                    cmd_arg.push_back(a);
                    cmd_mark.push_back(exp_chunk.size());
                end
            end
            $fclose(fd);
            timeout_cycles = 20 * (cmd_kind.size() + exp_chunk.size()) + 100;
        end
    endtask

    task automatic send_chunk(input marker_t markers);
        logic taken;
        chunk_valid   = 1'b1;
        chunk_markers = markers;
        do begin
            @(negedge clk);
            taken = chunk_ready;  // Transfer happens at the coming rising edge
            @(posedge clk);
        end while (!taken);
        #10;
    endtask

    // Everything listed so far must be out before the FIFOs get wiped
    task automatic wait_drained(input int mark);
        chunk_valid = 1'b0;
        wait (matched >= mark);
        repeat (3) @(posedge clk);
        #10;
    endtask

    task automatic hold_disabled(input int n);
        en = 1'b0;
        repeat (n) begin
            @(negedge clk);
            check_flag("chunk_ready with en low", chunk_ready, 1'b0);
            @(posedge clk);
            #10;
        end
        en = 1'b1;
    endtask

    task automatic pulse_flush();
        flush = 1'b1;
        @(posedge clk);
        #10;
        flush = 1'b0;
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (timeout_cycles > 0 && cycles > timeout_cycles) begin
            $display("Timed out after %0d cycles with %0d of %0d records delivered",
                     cycles, matched, exp_chunk.size());
            abort_run();
        end
    end

    // Output side with random back-pressure
    initial begin
        forever begin
            @(posedge clk);
            #10;
            seg_ready = (($random(seed) & 3) == 0);
            @(negedge clk);
            if (seg_valid && seg_ready) begin
                if (matched >= exp_chunk.size()) begin
                    $display("A segment record came out after the expected list was used up");
                    abort_run();
                end else begin
                    check_chunk(seg_chunk, exp_chunk[matched]);
                    check_loc(seg_loc, exp_loc[matched]);
                    matched = matched + 1;
                end
            end
        end
    end

    initial begin
        int sent;
        sent          = 0;
        rst_n         = 1'b0;
        en            = 1'b1;
        flush         = 1'b0;
        chunk_valid   = 1'b0;
        chunk_markers = '0;
        seg_ready     = 1'b0;
        load_testdata();
        repeat (3) @(posedge clk);
        #10;
        rst_n = 1'b1;

        for (int i = 0; i < cmd_kind.size(); i++) begin
            case (cmd_kind[i])
                "C": begin
                    send_chunk(marker_t'(cmd_arg[i]));
                    sent = sent + 1;
                    if (sent % 3 == 0) begin
                        chunk_valid = 1'b0;  // Gap in the chunk stream
                        @(posedge clk);
                        #10;
                    end
                end
                "D": begin
                    wait_drained(cmd_mark[i]);
                    hold_disabled(cmd_arg[i]);
                end
                default: begin
                    wait_drained(cmd_mark[i]);
                    pulse_flush();
                end
            endcase
        end
        chunk_valid = 1'b0;

        wait (matched == exp_chunk.size());
        repeat (10) begin
            @(negedge clk);
            if (seg_valid) begin
                $display("seg_valid rose again after all expected records were delivered");
                abort_run();
            end
        end
        $display("** PASS **");
        $finish;
    end

endmodule

// File: test/segment_testdata.txt
# C <marker bits from position 4 down to 0>   D <cycles with en low>   F for a flush
# E <chunk index> <start location> for each expected record in output order
C 01010
E 0 1
E 0 3
C 10001
E 1 0
C 00100
E 2 0
E 2 2
C 00000
C 01100
E 4 2
E 4 3
C 11000
E 5 3
C 10000
E 6 0
C 00010
E 7 0
E 7 1
C 10011
E 8 0
E 8 1
D 6
C 01000
E 9 0
E 9 3
C 10000
F
C 00011
E 0 0
E 0 1
C 10100
E 1 2
C 00000
E 2 0

// File: build.f
hw/segdisp_pkg.sv
hw/boundary_detector.sv
hw/fifo_controller.sv
hw/start_fifo.sv
hw/start_drain.sv
hw/segment_dispatch_top.sv
test/tb_segment_dispatch.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the segment dispatcher testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_segment_dispatch -f build.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
fi

if grep -q '^\*\* PASS \*\*$' sim.log; then
    echo "Simulation passed"
    exit 0
fi

echo "Simulation failed"
exit 1
